/* Bender.yml */
package:
  name: dual_issue_core

sources:
  - files:
      - hdl/issue_pkg.sv
      - hdl/issue_if.sv
      - hdl/fetch_receiver.sv
      - hdl/regfile_2.sv
      - hdl/execute_unit.sv
      - hdl/result_sender.sv
      - hdl/dual_issue_core.sv
  - target: simulation
    files:
      - tests/dual_issue_core_tb.sv

/* dual_issue_core.f */
hdl/issue_pkg.sv
hdl/issue_if.sv
hdl/fetch_receiver.sv
hdl/regfile_2.sv
hdl/execute_unit.sv
hdl/result_sender.sv
hdl/dual_issue_core.sv
tests/dual_issue_core_tb.sv

/* hdl/dual_issue_core.sv */
/*
  two-wide integer issue slice, fetch -> execute -> send
  both handshakes four-phase; up to three pairs in flight
  register file has no reset, read only what was written
*/
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core import issue_pkg::*; (
	input  logic            clock,
	input  logic            reset,

	// instruction pair in
	input  logic            in_req,
	output logic            in_ack,
	input  logic [31:0]     in_inst0,
	input  logic [31:0]     in_inst1,

	// result pair out
	output logic            out_req,
	input  logic            out_ack,
	output reg_idx_t        out_rd0,
	output reg_idx_t        out_rd1,
	output logic            out_wen0,
	output logic            out_wen1,
	output logic [xlen-1:0] out_data0,
	output logic [xlen-1:0] out_data1
);

	pair_if   pair_bus ();
	result_if result_bus ();

	//////////////////////////////////////////////////
	// stages
	fetch_receiver fetch (
		.clock    (clock),
		.reset    (reset),
		.in_req   (in_req),
		.in_inst0 (in_inst0),
		.in_inst1 (in_inst1),
		.in_ack   (in_ack),
		.pair     (pair_bus.source)
	);

	execute_unit exec (
		.clock  (clock),
		.reset  (reset),
		.pair   (pair_bus.sink),
		.result (result_bus.source)
	);

	result_sender send (
		.clock     (clock),
		.reset     (reset),
		.result    (result_bus.sink),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_rd0   (out_rd0),
		.out_rd1   (out_rd1),
		.out_wen0  (out_wen0),
		.out_wen1  (out_wen1),
		.out_data0 (out_data0),
		.out_data1 (out_data1)
	);

endmodule

`default_nettype wire

/* hdl/execute_unit.sv */
/*
  reads operands for both slots, computes both results in one cycle
  slot 1 sees slot 0's result through an in-stage bypass
  write-back happens in the result_if transfer cycle, so a pair taken in
  that same cycle gets the new values through regfile forwarding
*/
`timescale 1ns/1ps
`default_nettype none

module execute_unit import issue_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	pair_if.sink     pair,
	result_if.source result
);

	slot_t           s0, s1;
	logic [xlen-1:0] rs1_val_0, rs2_val_0;	// regfile outputs
	logic [xlen-1:0] rs1_val_1, rs2_val_1;
	logic [xlen-1:0] a0, b0, a1, b1;
	logic [xlen-1:0] alu_res_0, alu_res_1;
	logic            s0_fwd;	// slot 0 result is visible to slot 1
	logic            load, drain;

	// result register
	logic            res_valid;
	reg_idx_t        res_rd0, res_rd1;
	logic            res_wen0, res_wen1;
	logic [xlen-1:0] res_data0, res_data1;

	function automatic logic [xlen-1:0] alu(input alu_op_e op,
		input logic [xlen-1:0] a, input logic [xlen-1:0] b);
		case (op)
			alu_add: return a + b;
			alu_sub: return a - b;
			alu_xor: return a ^ b;
			alu_or:  return a | b;
			alu_and: return a & b;
			default: return '0;	// unsupported, result zero
		endcase
	endfunction

	assign s0 = pair.slot0;
	assign s1 = pair.slot1;

	//////////////////////////////////////////////////
	// handshakes
	assign drain     = result.valid && result.take;
	assign pair.take = pair.valid && (!res_valid || drain);
	assign load      = pair.valid && pair.take;

	regfile_2 rf (
		.clock     (clock),
		.rda_idx_0 (s0.rs1),
		.rdb_idx_0 (s0.rs2),
		.rda_idx_1 (s1.rs1),
		.rdb_idx_1 (s1.rs2),
		.wr_idx_0  (res_rd0),
		.wr_idx_1  (res_rd1),
		.wr_en_0   (res_wen0 && drain),	// write back on handoff only
		.wr_en_1   (res_wen1 && drain),
		.wr_data_0 (res_data0),
		.wr_data_1 (res_data1),
		.rda_out_0 (rs1_val_0),
		.rdb_out_0 (rs2_val_0),
		.rda_out_1 (rs1_val_1),
		.rdb_out_1 (rs2_val_1)
	);

	//////////////////////////////////////////////////
	// operands and alu
	assign a0        = rs1_val_0;
	assign b0        = s0.use_imm ? s0.imm : rs2_val_0;
	assign alu_res_0 = alu(s0.alu_op, a0, b0);

	assign s0_fwd = s0.writes && (s0.rd != zero_reg);

	// intra-pair bypass
	assign a1 = (s0_fwd && (s1.rs1 == s0.rd)) ? alu_res_0 : rs1_val_1;
	assign b1 = s1.use_imm ? s1.imm :
		(s0_fwd && (s1.rs2 == s0.rd)) ? alu_res_0 : rs2_val_1;
	assign alu_res_1 = alu(s1.alu_op, a1, b1);

	always_ff @(posedge clock) begin
		if (reset)
			res_valid <= 1'b0;
		else if (load)
			res_valid <= 1'b1;
		else if (drain)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (load) begin
			res_rd0   <= s0.rd;
			res_rd1   <= s1.rd;
			res_wen0  <= s0.writes;
			res_wen1  <= s1.writes;
			res_data0 <= alu_res_0;
			res_data1 <= alu_res_1;
		end
	end

	assign result.valid = res_valid;
	assign result.rd0   = res_rd0;
	assign result.rd1   = res_rd1;
	assign result.wen0  = res_wen0;
	assign result.wen1  = res_wen1;
	assign result.data0 = res_data0;
	assign result.data1 = res_data1;

endmodule

`default_nettype wire

/* hdl/fetch_receiver.sv */
/*
  four-phase req/ack input side, one raw pair buffer
  source must hold in_inst0/1 stable while in_req is high
  unsupported opcodes leave here as alu_none with writes clear
*/
`timescale 1ns/1ps
`default_nettype none

module fetch_receiver import issue_pkg::*; (
	input  logic        clock,
	input  logic        reset,
	input  logic        in_req,
	input  logic [31:0] in_inst0,
	input  logic [31:0] in_inst1,
	output logic        in_ack,
	pair_if.source      pair
);

	instr_word_u raw0, raw1;	// latched words, no reset
	logic        full;
	logic        grab;

	// decode one word through the R or I view
	function automatic slot_t decode(input instr_word_u w);
		slot_t s;
		s        = '0;
		s.alu_op = alu_none;
		s.rd     = w.r.rd;	// same bits in both views
		case (w.r.opcode)
			opc_op: begin
				s.rs1 = w.r.rs1;
				s.rs2 = w.r.rs2;
				case (w.r.funct3)
					f3_add:  s.alu_op = (w.r.funct7 == f7_sub) ? alu_sub : alu_add;
					f3_xor:  s.alu_op = alu_xor;
					f3_or:   s.alu_op = alu_or;
					f3_and:  s.alu_op = alu_and;
					default: s.alu_op = alu_none;	// shifts, slt
				endcase
			end
			opc_op_imm: begin
				s.rs1     = w.i.rs1;
				s.rs2     = zero_reg;	// no second source
				s.use_imm = 1'b1;
				s.imm     = {{(xlen-12){w.i.imm[11]}}, w.i.imm};
				case (w.i.funct3)
					f3_add:  s.alu_op = alu_add;
					f3_xor:  s.alu_op = alu_xor;
					f3_or:   s.alu_op = alu_or;
					f3_and:  s.alu_op = alu_and;
					default: s.alu_op = alu_none;
				endcase
			end
			default: s.alu_op = alu_none;	// carried through, no write
		endcase
		s.writes = (s.alu_op != alu_none);
		return s;
	endfunction

	// new pair only into an empty buffer, and not twice per req
	assign grab = in_req && !in_ack && !full;

	always_ff @(posedge clock) begin
		if (reset) begin
			in_ack <= 1'b0;
			full   <= 1'b0;
		end else begin
			if (grab)
				in_ack <= 1'b1;
			else if (!in_req)
				in_ack <= 1'b0;	// one cycle after req low
			if (grab)
				full <= 1'b1;
			else if (pair.valid && pair.take)
				full <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (grab) begin
			raw0 <= in_inst0;
			raw1 <= in_inst1;
		end
	end

	assign pair.valid = full;	// rises with in_ack
	assign pair.slot0 = decode(raw0);
	assign pair.slot1 = decode(raw1);

	// ack holds for as long as the source keeps req up
	a_ack_hold: assert property (@(posedge clock) disable iff (reset)
		in_ack && in_req |=> in_ack);

endmodule

`default_nettype wire

/* hdl/issue_if.sv */
/*
  stage-to-stage links; a transfer is valid && take in one cycle
  source holds valid and payload stable until the transfer
*/
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////
// decoded pair, fetch -> execute
interface pair_if import issue_pkg::*; ();
	logic  valid;
	logic  take;
	slot_t slot0;	// older instruction
	slot_t slot1;

	modport source (output valid, slot0, slot1, input take);
	modport sink   (input valid, slot0, slot1, output take);
endinterface

//////////////////////////////////////////////////
// result pair, execute -> sender
interface result_if import issue_pkg::*; ();
	logic            valid;
	logic            take;
	reg_idx_t        rd0, rd1;
	logic            wen0, wen1;
	logic [xlen-1:0] data0, data1;	// zero when wen low

	modport source (
		output valid, rd0, rd1, wen0, wen1, data0, data1,
		input  take
	);
	modport sink (
		input  valid, rd0, rd1, wen0, wen1, data0, data1,
		output take
	);
endinterface

`default_nettype wire

/* hdl/issue_pkg.sv */
/*
  shared constants and types for the two-wide issue slice
  RV32I only, OP and OP-IMM groups; shifts and compares decode as unsupported
  slot_t imm is already sign-extended by the decoder
*/
`default_nettype none

package issue_pkg;

	//////////////////////////////////////////////////
	// widths and register space
	localparam int xlen      = 32;
	localparam int reg_count = 32;

	typedef logic [4:0] reg_idx_t;

	localparam reg_idx_t zero_reg = 5'd0;	// x0, hardwired zero

	//////////////////////////////////////////////////
	// encodings
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;

	localparam logic [2:0] f3_add = 3'b000;	// also addi, sub
	localparam logic [2:0] f3_xor = 3'b100;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [6:0] f7_sub = 7'b0100000;

	// output sequencer states
	localparam logic [1:0] snd_idle = 2'd0;
	localparam logic [1:0] snd_req  = 2'd1;
	localparam logic [1:0] snd_wait = 2'd2;	// ack seen, waiting for it to drop

	// one word, read as R or I format
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm;
			reg_idx_t    rs1;
			logic [2:0]  funct3;
			reg_idx_t    rd;
			logic [6:0]  opcode;
		} i;
	} instr_word_u;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_xor, alu_or, alu_and, alu_none} alu_op_e;

	// decoded slot, 52 bits
	typedef struct packed {
		alu_op_e         alu_op;
		reg_idx_t        rs1;
		reg_idx_t        rs2;
		reg_idx_t        rd;
		logic            use_imm;	// operand b from imm
		logic [xlen-1:0] imm;
		logic            writes;	// rd write enable
	} slot_t;

endpackage

`default_nettype wire

/* hdl/regfile_2.sv */
/*
  32x32 register file, four read ports, two write ports, no reset
  reads forward same-cycle write data, slot 1 over slot 0
  x0 reads zero whatever was written to it
*/
`timescale 1ns/1ps
`default_nettype none

module regfile_2 import issue_pkg::*; (
	input  logic            clock,

	input  reg_idx_t        rda_idx_0, rdb_idx_0,	// slot 0 sources
	input  reg_idx_t        rda_idx_1, rdb_idx_1,	// slot 1 sources

	input  reg_idx_t        wr_idx_0, wr_idx_1,
	input  logic            wr_en_0, wr_en_1,
	input  logic [xlen-1:0] wr_data_0, wr_data_1,

	output logic [xlen-1:0] rda_out_0, rdb_out_0,
	output logic [xlen-1:0] rda_out_1, rdb_out_1
);

	logic [reg_count-1:0][xlen-1:0] registers;

	// one read port: zero reg, then forwarding, then array
	function automatic logic [xlen-1:0] read_port(input reg_idx_t idx);
		logic [xlen-1:0] val;
		if (idx == zero_reg)
			val = '0;
		else if (wr_en_1 && (wr_idx_1 == idx))
			val = wr_data_1;	// younger write first
		else if (wr_en_0 && (wr_idx_0 == idx))
			val = wr_data_0;
		else
			val = registers[idx];
		return val;
	endfunction

	//////////////////////////////////////////////////
	// read ports
	always_comb begin
		rda_out_0 = read_port(rda_idx_0);
	end

	always_comb begin
		rdb_out_0 = read_port(rdb_idx_0);
	end

	always_comb begin
		rda_out_1 = read_port(rda_idx_1);
	end

	always_comb begin
		rdb_out_1 = read_port(rdb_idx_1);
	end

	//////////////////////////////////////////////////
	// write ports
	always_ff @(posedge clock) begin
		// same index on both ports, slot 1 keeps it
		if (wr_en_0 && !(wr_en_1 && (wr_idx_1 == wr_idx_0)))
			registers[wr_idx_0] <= wr_data_0;
		if (wr_en_1)
			registers[wr_idx_1] <= wr_data_1;
	end

	// a write with an unknown index would corrupt an unknown register
	a_wr_idx_0_known: assert property (@(posedge clock)
		wr_en_0 |-> !$isunknown(wr_idx_0));
	a_wr_idx_1_known: assert property (@(posedge clock)
		wr_en_1 |-> !$isunknown(wr_idx_1));

endmodule

`default_nettype wire

/* hdl/result_sender.sv */
/*
  four-phase req/ack output side with one holding register
  out_* fields are stable while out_req is high
  next pair accepted only once out_ack has dropped
*/
`timescale 1ns/1ps
`default_nettype none

module result_sender import issue_pkg::*; (
	input  logic            clock,
	input  logic            reset,
	result_if.sink          result,
	output logic            out_req,
	input  logic            out_ack,
	output reg_idx_t        out_rd0,
	output reg_idx_t        out_rd1,
	output logic            out_wen0,
	output logic            out_wen1,
	output logic [xlen-1:0] out_data0,
	output logic [xlen-1:0] out_data1
);

	logic [1:0] state;
	logic       accept;

	assign result.take = result.valid && (state == snd_idle);
	assign accept      = result.valid && result.take;

	//////////////////////////////////////////////////
	// sequencer
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= snd_idle;
		end else begin
			case (state)
				snd_idle: if (accept) state <= snd_req;
				snd_req:  if (out_ack) state <= snd_wait;	// req drops next
				snd_wait: if (!out_ack) state <= snd_idle;
				default:  state <= snd_idle;
			endcase
		end
	end

	// holding register
	always_ff @(posedge clock) begin
		if (accept) begin
			out_rd0   <= result.rd0;
			out_rd1   <= result.rd1;
			out_wen0  <= result.wen0;
			out_wen1  <= result.wen1;
			out_data0 <= result.data0;
			out_data1 <= result.data1;
		end
	end

	assign out_req = (state == snd_req);

	// req never withdrawn before the sink answers
	a_req_hold: assert property (@(posedge clock) disable iff (reset)
		out_req && !out_ack |=> out_req);

endmodule

`default_nettype wire

/* tests/dual_issue_core_tb.sv */
/*
  testbench for the two-wide issue slice
  expected values come from a register model run over the table before the run
  every register is written before it is read, the DUT regfile has no reset
*/
`timescale 1ns/1ps
`default_nettype none

module dual_issue_core_tb;

	localparam int table_len      = 24;
	localparam int reset_cycles   = 10;
	localparam int timeout_cycles = 40 * table_len + reset_cycles;

	// encodings, straight from the ISA manual
	localparam logic [2:0] fn_add  = 3'b000;
	localparam logic [2:0] fn_xor  = 3'b100;
	localparam logic [2:0] fn_or   = 3'b110;
	localparam logic [2:0] fn_and  = 3'b111;
	localparam logic [6:0] fn7_sub = 7'b0100000;

	logic        clock, reset;
	logic        in_req, in_ack;
	logic [31:0] in_inst0, in_inst1;
	logic        out_req, out_ack;
	logic [4:0]  out_rd0, out_rd1;
	logic        out_wen0, out_wen1;
	logic [31:0] out_data0, out_data1;

	// stimulus and expected table
	logic [31:0] inst0 [table_len];
	logic [31:0] inst1 [table_len];
	logic [4:0]  exp_rd0 [table_len];
	logic [4:0]  exp_rd1 [table_len];
	logic        exp_wen0 [table_len];
	logic        exp_wen1 [table_len];
	logic [31:0] exp_data0 [table_len];
	logic [31:0] exp_data1 [table_len];
	logic [31:0] ref_regs [32];	// model register state

	int fill        = 0;
	int collected   = 0;	// pairs seen at the sink
	int error_count = 0;
	int cycle_count = 0;
	int req_rises   = 0;	// out_req rising edges, any number
	logic out_req_q = 1'b0;

	dual_issue_core UUT (
		.clock     (clock),
		.reset     (reset),
		.in_req    (in_req),
		.in_ack    (in_ack),
		.in_inst0  (in_inst0),
		.in_inst1  (in_inst1),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_rd0   (out_rd0),
		.out_rd1   (out_rd1),
		.out_wen0  (out_wen0),
		.out_wen1  (out_wen1),
		.out_data0 (out_data0),
		.out_data1 (out_data1)
	);

	always #4 clock = ~clock;	// 8 ns period

	//////////////////////////////////////////////////
	// instruction words and table
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, 7'b0010011};
	endfunction

	task automatic add_pair(input logic [31:0] w0, input logic [31:0] w1);
		inst0[fill] = w0;
		inst1[fill] = w1;
		fill = fill + 1;
	endtask

	task automatic build_table();
		add_pair(i_word(12'd5, 0, fn_add, 1), i_word(12'hffd, 0, fn_add, 2));	// x1 5, x2 -3
		add_pair(i_word(12'h7ff, 0, fn_add, 3), i_word(12'h800, 0, fn_add, 4));	// imm extremes
		add_pair(r_word(0, 2, 1, fn_add, 5), r_word(fn7_sub, 2, 1, fn_add, 6));
		add_pair(r_word(0, 4, 3, fn_xor, 7), r_word(0, 4, 3, fn_or, 8));
		add_pair(r_word(0, 3, 2, fn_and, 9), r_word(0, 1, 0, fn_add, 10));	// x0 as rs1
		add_pair(i_word(12'h0f0, 2, fn_xor, 11), i_word(12'h500, 1, fn_or, 12));
		add_pair(i_word(12'h03c, 2, fn_and, 13), r_word(0, 1, 13, fn_add, 14));	// bypass on rs1
		add_pair(i_word(12'd10, 1, fn_add, 15), r_word(fn7_sub, 15, 1, fn_add, 16));	// on rs2
		add_pair(i_word(12'd100, 0, fn_add, 17), i_word(12'd9, 0, fn_add, 17));	// same rd
		add_pair(r_word(0, 1, 17, fn_add, 18), r_word(0, 0, 17, fn_xor, 19));	// x17 must be 9
		add_pair(r_word(0, 6, 5, fn_add, 21), i_word(12'd33, 0, fn_add, 22));
		add_pair(r_word(fn7_sub, 22, 21, fn_add, 23), r_word(0, 22, 21, fn_and, 24));
		add_pair(r_word(0, 24, 23, fn_or, 25), i_word(12'hfff, 23, fn_xor, 26));
		add_pair({12'd12, 5'd1, 3'b010, 5'd5, 7'b0000011}, r_word(0, 0, 5, fn_add, 27));	// lw
		add_pair(r_word(0, 1, 6, fn_add, 28), r_word(0, 2, 1, 3'b001, 6));	// sll unsupported
		add_pair(r_word(0, 0, 6, fn_add, 29), i_word(12'd55, 1, fn_add, 0));	// x6 kept, x0 write
		add_pair(i_word(12'd5, 1, fn_add, 0), r_word(0, 1, 0, fn_add, 30));
		add_pair(r_word(fn7_sub, 1, 0, fn_add, 1), r_word(0, 1, 1, fn_add, 2));
		add_pair(r_word(0, 2, 1, fn_xor, 3), r_word(0, 1, 3, fn_and, 4));
		add_pair(i_word(12'hfff, 0, fn_or, 5), i_word(12'h7ff, 5, fn_and, 6));
		add_pair(r_word(0, 6, 5, fn_add, 7), r_word(0, 7, 7, fn_or, 8));
		add_pair(i_word(12'hf9c, 8, fn_add, 9), r_word(fn7_sub, 8, 9, fn_add, 10));
		add_pair(r_word(0, 9, 10, fn_xor, 11), i_word(12'd1, 11, fn_add, 11));	// dep, same rd
		add_pair(r_word(0, 0, 11, fn_add, 12), r_word(0, 12, 11, fn_and, 13));
	endtask

	//////////////////////////////////////////////////
	// reference model, returns {wen, data}
	function automatic logic [32:0] model_slot(input logic [31:0] w);
		logic        is_op, is_imm;
		logic [31:0] a, b;
		logic [32:0] r;
		is_op  = (w[6:0] == 7'b0110011);
		is_imm = (w[6:0] == 7'b0010011);
		a      = ref_regs[w[19:15]];
		b      = is_op ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
		r      = 33'd0;	// unsupported: no write, zero
		if (is_op || is_imm) begin
			case (w[14:12])
				fn_add: r = {1'b1, (is_op && w[31:25] == fn7_sub) ? a - b : a + b};
				fn_xor: r = {1'b1, a ^ b};
				fn_or:  r = {1'b1, a | b};
				fn_and: r = {1'b1, a & b};
				default: r = 33'd0;
			endcase
		end
		return r;
	endfunction

	task automatic compute_expected();
		logic [32:0] r0, r1;
		foreach (ref_regs[k])
			ref_regs[k] = 32'd0;
		for (int i = 0; i < table_len; i++) begin
			r0 = model_slot(inst0[i]);
			if (r0[32])
				ref_regs[inst0[i][11:7]] = r0[31:0];
			ref_regs[0] = 32'd0;	// slot 1 then sees slot 0's result
			r1 = model_slot(inst1[i]);
			if (r1[32])
				ref_regs[inst1[i][11:7]] = r1[31:0];	// slot 1 wins on equal rd
			ref_regs[0] = 32'd0;
			exp_rd0[i]   = inst0[i][11:7];
			exp_rd1[i]   = inst1[i][11:7];
			exp_wen0[i]  = r0[32];
			exp_wen1[i]  = r1[32];
			exp_data0[i] = r0[31:0];
			exp_data1[i] = r1[31:0];
		end
	endtask

	//////////////////////////////////////////////////
	// checks and handshakes
	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			error_count = error_count + 1;
			$display("Error %s: got %h expected %h", name, got, expected);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// four-phase source, entered just after a rising edge
	task automatic send_pair(input logic [31:0] w0, input logic [31:0] w1);
		in_inst0 <= w0;
		in_inst1 <= w1;
		in_req   <= 1'b1;
		do @(posedge clock); while (in_ack !== 1'b1);
		in_req <= 1'b0;
		do @(posedge clock); while (in_ack !== 1'b0);
	endtask

	// timeout
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > timeout_cycles) begin
			$display("timeout, only %0d of %0d result pairs arrived", collected, table_len);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

	// every request the DUT raises, seen apart from the sink loop
	always @(posedge clock) begin
		if (out_req === 1'b1 && out_req_q !== 1'b1)
			req_rises = req_rises + 1;
		out_req_q = out_req;
	end

	// sink with random ack delay
	initial begin : sink
		int delay;
		void'($urandom(32'h0ee05cfd));
		for (int k = 0; k < table_len; k++) begin
			do @(posedge clock); while (out_req !== 1'b1);
			delay = $urandom % 4;
			repeat (delay) @(posedge clock);	// out_* held while req is up
			check_value("out_rd0", out_rd0, exp_rd0[k]);
			check_value("out_rd1", out_rd1, exp_rd1[k]);
			check_value("out_wen0", out_wen0, exp_wen0[k]);
			check_value("out_wen1", out_wen1, exp_wen1[k]);
			check_value("out_data0", out_data0, exp_data0[k]);
			check_value("out_data1", out_data1, exp_data1[k]);
			out_ack <= 1'b1;
			do @(posedge clock); while (out_req !== 1'b0);
			out_ack <= 1'b0;
			collected = collected + 1;
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	initial begin
		clock    = 1'b0;
		reset    = 1'b1;
		in_req   = 1'b0;
		in_inst0 = 32'd0;
		in_inst1 = 32'd0;
		out_ack  = 1'b0;
		build_table();
		compute_expected();
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < table_len; i++)
			send_pair(inst0[i], inst1[i]);
		wait (collected == table_len);
		repeat (20) @(posedge clock);	// nothing extra may follow
		check_value("out_req", out_req, 32'd0);
		check_value("pair_count", req_rises, table_len);
		if (error_count == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("TEST FAIL");
			$fatal(1, "%0d checks failed", error_count);
		end
	end

endmodule

`default_nettype wire
